//--- rtl/fb_defines.svh
`ifndef FB_DEFINES_SVH
`define FB_DEFINES_SVH

// frame store geometry
`define FB_NUM_SLOTS    3
`define FB_ADDR_W       21
`define FB_FRAME_W      640
`define FB_FRAME_H      480

// gap left after each frame so bursts never run into the next slot
`define FB_BURST        32
`define FB_SLOT_STRIDE  (`FB_FRAME_W * `FB_FRAME_H + `FB_BURST)

// cycles to wait after memory init before touching the buffers
`define FB_START_DELAY  152

`endif

//--- rtl/fb_pkg.sv
`default_nettype none

`include "fb_defines.svh"

package fb_pkg;

    typedef logic [`FB_ADDR_W-1:0] fb_addr_t;

    typedef logic [1:0] fb_slot_idx_t;

    typedef enum logic [2:0] {
        AVAILABLE,
        WRITE_BUSY,
        READ_BUSY,
        DISPLAYED,
        UPDATED
    } slot_state_e;

    typedef enum logic [2:0] {
        IDLE,
        WAIT_READY,
        LOCK,
        START,
        BUSY,
        RELEASE_LOCK,
        RELEASE
    } stream_state_e;

    // slot i occupies bits [3*i +: 3]
    typedef logic [`FB_NUM_SLOTS*3-1:0] slot_states_t;

endpackage

`default_nettype wire

//--- rtl/fb_start_delay.sv
`timescale 1ns/1ps
`default_nettype none

`include "fb_defines.svh"

module fb_start_delay (
    input  logic clk,
    input  logic rst_n,
    input  logic init_done_i,
    output logic ready_o
);

    localparam int CNT_W = $clog2(`FB_START_DELAY + 1);
    localparam logic [CNT_W-1:0] DELAY = CNT_W'(`FB_START_DELAY);

    logic [CNT_W-1:0] cnt_q;

    // saturates at the delay, so ready stays up for good
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q <= '0;
        end else if (init_done_i && !ready_o) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    assign ready_o = (cnt_q == DELAY);

endmodule

`default_nettype wire

//--- rtl/fb_stream_seq.sv
`timescale 1ns/1ps
`default_nettype none

module fb_stream_seq (
    input  logic clk,
    input  logic rst_n,
    input  logic ready_i,
    input  logic grant_i,
    input  logic done_i,
    output logic lock_req_o,
    output logic start_o,
    output logic release_phase_o
);

    import fb_pkg::*;

    stream_state_e state_q;
    stream_state_e state_d;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                state_d = WAIT_READY;
            end
            WAIT_READY: begin
                if (ready_i) begin
                    state_d = LOCK;
                end
            end
            LOCK: begin
                // broker claims a slot in the grant cycle
                if (grant_i) begin
                    state_d = START;
                end
            end
            START: begin
                state_d = BUSY;
            end
            BUSY: begin
                if (done_i) begin
                    state_d = RELEASE_LOCK;
                end
            end
            RELEASE_LOCK: begin
                if (grant_i) begin
                    state_d = RELEASE;
                end
            end
            RELEASE: begin
                state_d = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    assign lock_req_o      = (state_q == LOCK) || (state_q == RELEASE_LOCK);
    assign release_phase_o = (state_q == RELEASE_LOCK);
    assign start_o         = (state_q == START);

    a_grant_has_req: assert property (@(posedge clk) disable iff (!rst_n)
        grant_i |-> lock_req_o)
        else $error("grant without a pending lock request");

    // done from outside BUSY is dropped
    a_done_in_busy: assert property (@(posedge clk) disable iff (!rst_n)
        done_i |-> (state_q == BUSY))
        else $warning("done strobe ignored outside BUSY");

endmodule

`default_nettype wire

//--- rtl/fb_buffer_broker.sv
`timescale 1ns/1ps
`default_nettype none

`include "fb_defines.svh"

module fb_buffer_broker (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     wr_lock_req_i,
    input  logic                     rd_lock_req_i,
    input  logic                     wr_release_i,
    input  logic                     rd_release_i,
    input  fb_pkg::slot_states_t     slot_states_i,
    output logic                     wr_grant_o,
    output logic                     rd_grant_o,
    output logic [`FB_NUM_SLOTS-1:0] claim_wr_o,
    output logic [`FB_NUM_SLOTS-1:0] claim_rd_o,
    output logic [`FB_NUM_SLOTS-1:0] release_wr_o,
    output logic [`FB_NUM_SLOTS-1:0] release_rd_o
);

    import fb_pkg::*;

    localparam int ST_W = $bits(slot_state_e);

    // set when the reader wins a tie
    logic         rr_rd_q;
    fb_slot_idx_t wr_idx_q;
    fb_slot_idx_t rd_idx_q;
    logic         wr_found;
    logic         rd_found;
    fb_slot_idx_t wr_sel;
    fb_slot_idx_t rd_sel;
    logic         wr_claim;
    logic         rd_claim;

    // {found, index} of the best slot for the given class order
    function automatic logic [2:0] pick_slot(
        input slot_states_t states,
        input slot_state_e  first,
        input slot_state_e  second,
        input slot_state_e  third
    );
        slot_state_e order [3];
        logic [2:0]  hit;
        order[0] = first;
        order[1] = second;
        order[2] = third;
        hit = '0;
        // weakest class and highest index first, later matches win
        for (int c = 2; c >= 0; c--) begin
            for (int i = `FB_NUM_SLOTS - 1; i >= 0; i--) begin
                if (states[i*ST_W +: ST_W] == order[c]) begin
                    hit = {1'b1, fb_slot_idx_t'(i)};
                end
            end
        end
        return hit;
    endfunction

    assign {wr_found, wr_sel} = pick_slot(slot_states_i, DISPLAYED, AVAILABLE, UPDATED);
    assign {rd_found, rd_sel} = pick_slot(slot_states_i, UPDATED, AVAILABLE, DISPLAYED);

    assign wr_grant_o = wr_lock_req_i && (!rd_lock_req_i || !rr_rd_q);
    assign rd_grant_o = rd_lock_req_i && (!wr_lock_req_i || rr_rd_q);

    assign wr_claim = wr_grant_o && !wr_release_i;
    assign rd_claim = rd_grant_o && !rd_release_i;

    always_comb begin
        claim_wr_o   = '0;
        claim_rd_o   = '0;
        release_wr_o = '0;
        release_rd_o = '0;
        if (wr_claim) begin
            claim_wr_o[wr_sel] = 1'b1;
        end
        if (wr_grant_o && wr_release_i) begin
            release_wr_o[wr_idx_q] = 1'b1;
        end
        if (rd_claim) begin
            claim_rd_o[rd_sel] = 1'b1;
        end
        if (rd_grant_o && rd_release_i) begin
            release_rd_o[rd_idx_q] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rr_rd_q  <= 1'b0;
            wr_idx_q <= '0;
            rd_idx_q <= '0;
        end else begin
            if (wr_grant_o) begin
                rr_rd_q <= 1'b1;
            end else if (rd_grant_o) begin
                rr_rd_q <= 1'b0;
            end
            if (wr_claim) begin
                wr_idx_q <= wr_sel;
            end
            if (rd_claim) begin
                rd_idx_q <= rd_sel;
            end
        end
    end

    // three slots and two streams leave one slot free at every claim
    a_claim_finds_slot: assert property (@(posedge clk) disable iff (!rst_n)
        (wr_claim |-> wr_found) and (rd_claim |-> rd_found))
        else $error("claim found no free slot");

endmodule

`default_nettype wire

//--- rtl/fb_slot.sv
`timescale 1ns/1ps
`default_nettype none

`include "fb_defines.svh"

module fb_slot #(
    parameter int SLOT_INDEX = 0
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                claim_wr_i,
    input  logic                claim_rd_i,
    input  logic                release_wr_i,
    input  logic                release_rd_i,
    output fb_pkg::slot_state_e state_o,
    output fb_pkg::fb_addr_t    base_o
);

    import fb_pkg::*;

    localparam fb_addr_t BASE = fb_addr_t'(SLOT_INDEX * `FB_SLOT_STRIDE);

    slot_state_e state_q;

    // broker grants one stream per cycle, so at most one strobe is set
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= AVAILABLE;
        end else if (claim_wr_i) begin
            state_q <= WRITE_BUSY;
        end else if (claim_rd_i) begin
            state_q <= READ_BUSY;
        end else if (release_wr_i) begin
            state_q <= UPDATED;
        end else if (release_rd_i) begin
            state_q <= DISPLAYED;
        end
    end

    assign state_o = state_q;
    assign base_o  = BASE;

    a_release_matches: assert property (@(posedge clk) disable iff (!rst_n)
        (release_wr_i |-> state_q == WRITE_BUSY) and
        (release_rd_i |-> state_q == READ_BUSY))
        else $error("release hit slot %0d in state %s", SLOT_INDEX, state_q.name());

endmodule

`default_nettype wire

//--- rtl/fb_slot_collect.sv
`timescale 1ns/1ps
`default_nettype none

`include "fb_defines.svh"

module fb_slot_collect (
    input  logic                     clk,
    input  logic                     rst_n,
    input  fb_pkg::slot_state_e      slot_state_i [`FB_NUM_SLOTS],
    input  fb_pkg::fb_addr_t         slot_base_i [`FB_NUM_SLOTS],
    input  logic [`FB_NUM_SLOTS-1:0] claim_wr_i,
    input  logic [`FB_NUM_SLOTS-1:0] claim_rd_i,
    output fb_pkg::slot_states_t     slot_states_o,
    output fb_pkg::fb_addr_t         wr_base_o,
    output fb_pkg::fb_addr_t         rd_base_o
);

    import fb_pkg::*;

    localparam int ST_W = $bits(slot_state_e);

    fb_addr_t wr_base_d;
    fb_addr_t rd_base_d;

    always_comb begin
        for (int i = 0; i < `FB_NUM_SLOTS; i++) begin
            slot_states_o[i*ST_W +: ST_W] = slot_state_i[i];
        end
    end

    // base of the claimed slot, held until the next claim
    always_comb begin
        wr_base_d = wr_base_o;
        rd_base_d = rd_base_o;
        for (int i = 0; i < `FB_NUM_SLOTS; i++) begin
            if (claim_wr_i[i]) begin
                wr_base_d = slot_base_i[i];
            end
            if (claim_rd_i[i]) begin
                rd_base_d = slot_base_i[i];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_base_o <= '0;
            rd_base_o <= '0;
        end else begin
            wr_base_o <= wr_base_d;
            rd_base_o <= rd_base_d;
        end
    end

endmodule

`default_nettype wire

//--- rtl/fb_manager.sv
`timescale 1ns/1ps
`default_nettype none

`include "fb_defines.svh"

module fb_manager (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             init_done_i,
    input  logic             wr_done_i,
    input  logic             rd_done_i,
    output logic             wr_start_o,
    output logic             rd_start_o,
    output fb_pkg::fb_addr_t wr_base_o,
    output fb_pkg::fb_addr_t rd_base_o
);

    import fb_pkg::*;

    logic                     ready;
    logic                     wr_lock_req;
    logic                     rd_lock_req;
    logic                     wr_release;
    logic                     rd_release;
    logic                     wr_grant;
    logic                     rd_grant;
    logic [`FB_NUM_SLOTS-1:0] claim_wr;
    logic [`FB_NUM_SLOTS-1:0] claim_rd;
    logic [`FB_NUM_SLOTS-1:0] release_wr;
    logic [`FB_NUM_SLOTS-1:0] release_rd;
    slot_state_e              slot_state [`FB_NUM_SLOTS];
    fb_addr_t                 slot_base [`FB_NUM_SLOTS];
    slot_states_t             slot_states;

    fb_start_delay u_start_delay (
        .clk         (clk),
        .rst_n       (rst_n),
        .init_done_i (init_done_i),
        .ready_o     (ready)
    );

    fb_stream_seq u_wr_seq (
        .clk             (clk),
        .rst_n           (rst_n),
        .ready_i         (ready),
        .grant_i         (wr_grant),
        .done_i          (wr_done_i),
        .lock_req_o      (wr_lock_req),
        .start_o         (wr_start_o),
        .release_phase_o (wr_release)
    );

    fb_stream_seq u_rd_seq (
        .clk             (clk),
        .rst_n           (rst_n),
        .ready_i         (ready),
        .grant_i         (rd_grant),
        .done_i          (rd_done_i),
        .lock_req_o      (rd_lock_req),
        .start_o         (rd_start_o),
        .release_phase_o (rd_release)
    );

    fb_buffer_broker u_broker (
        .clk           (clk),
        .rst_n         (rst_n),
        .wr_lock_req_i (wr_lock_req),
        .rd_lock_req_i (rd_lock_req),
        .wr_release_i  (wr_release),
        .rd_release_i  (rd_release),
        .slot_states_i (slot_states),
        .wr_grant_o    (wr_grant),
        .rd_grant_o    (rd_grant),
        .claim_wr_o    (claim_wr),
        .claim_rd_o    (claim_rd),
        .release_wr_o  (release_wr),
        .release_rd_o  (release_rd)
    );

    for (genvar g = 0; g < `FB_NUM_SLOTS; g++) begin : g_slot
        fb_slot #(
            .SLOT_INDEX (g)
        ) u_slot (
            .clk          (clk),
            .rst_n        (rst_n),
            .claim_wr_i   (claim_wr[g]),
            .claim_rd_i   (claim_rd[g]),
            .release_wr_i (release_wr[g]),
            .release_rd_i (release_rd[g]),
            .state_o      (slot_state[g]),
            .base_o       (slot_base[g])
        );
    end

    fb_slot_collect u_collect (
        .clk           (clk),
        .rst_n         (rst_n),
        .slot_state_i  (slot_state),
        .slot_base_i   (slot_base),
        .claim_wr_i    (claim_wr),
        .claim_rd_i    (claim_rd),
        .slot_states_o (slot_states),
        .wr_base_o     (wr_base_o),
        .rd_base_o     (rd_base_o)
    );

endmodule

`default_nettype wire

//--- dv/fb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module fb_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);

    localparam int HALF_PERIOD  = 10;
    localparam int RESET_CYCLES = 8;

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD) clk_o = ~clk_o;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

`default_nettype wire

//--- dv/fb_manager_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "fb_defines.svh"

module fb_manager_tb;

    import fb_pkg::*;

    localparam int unsigned SEED        = 32'he7c71d58;
    localparam int          RESET_WAIT  = 50;
    localparam int          START_WAIT  = 400;
    localparam int          EVENT_WAIT  = 100;
    localparam int          QUIET_SPAN  = 300;
    localparam int          WATCH_SPAN  = 60;
    localparam int          ALT_ROUNDS  = 12;
    localparam fb_addr_t    STRIDE      = fb_addr_t'(`FB_SLOT_STRIDE);

    logic     clk;
    logic     rst_n;
    logic     init_done;
    logic     wr_done;
    logic     rd_done;
    logic     wr_start;
    logic     rd_start;
    fb_addr_t wr_base;
    fb_addr_t rd_base;

    // reference slot model, kept by the monitor
    slot_states_t model;
    int           wr_held;
    int           rd_held;
    int           mon_slot;
    fb_addr_t     mon_exp;
    int           errors;
    int           tests_run;
    int           tests_failed;

    fb_clk_gen u_clk_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    fb_manager fb_manager_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .init_done_i (init_done),
        .wr_done_i   (wr_done),
        .rd_done_i   (rd_done),
        .wr_start_o  (wr_start),
        .rd_start_o  (rd_start),
        .wr_base_o   (wr_base),
        .rd_base_o   (rd_base)
    );

    function automatic slot_states_t set_slot(input slot_states_t st, input int idx,
                                              input slot_state_e s);
        slot_states_t r;
        r = st;
        r[idx*$bits(slot_state_e) +: $bits(slot_state_e)] = s;
        return r;
    endfunction

    // writer wants DISPLAYED first, reader UPDATED first; lowest index inside a class
    function automatic fb_addr_t expect_base(input slot_states_t st, input logic is_rd,
                                             output int slot);
        slot_state_e pref [3];
        fb_addr_t    base;
        slot = -1;
        base = '0;
        pref[1] = AVAILABLE;
        if (is_rd) begin
            pref[0] = UPDATED;
            pref[2] = DISPLAYED;
        end else begin
            pref[0] = DISPLAYED;
            pref[2] = UPDATED;
        end
        for (int c = 0; c < 3; c++) begin
            for (int i = 0; i < `FB_NUM_SLOTS; i++) begin
                if (slot < 0 && st[i*$bits(slot_state_e) +: $bits(slot_state_e)] == pref[c]) begin
                    slot = i;
                end
            end
        end
        if (slot >= 0) begin
            base = fb_addr_t'(slot) * STRIDE;
        end
        return base;
    endfunction

    task automatic check_addr(input string name, input fb_addr_t got, input fb_addr_t exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_distinct(input fb_addr_t wr, input fb_addr_t rd);
        if (wr === rd) begin
            $display("FAILED rd_base_o: equals wr_base_o, both 0x%h", rd);
            errors++;
        end
    endtask

    task automatic finish_run();
        $display("tests run: %0d, tests failed: %0d, check errors: %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    endtask

    task automatic timed_out(input string what);
        $display("timeout while waiting for %s", what);
        errors++;
        finish_run();
    endtask

    task automatic end_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("test %0d %s: passed", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed", tests_run, name);
        end
    endtask

    task automatic wait_reset();
        int n;
        n = 0;
        while (rst_n !== 1'b1) begin
            @(posedge clk);
            n++;
            if (n >= RESET_WAIT) begin
                timed_out("reset release");
            end
        end
    endtask

    // next start strobe of one stream and the base it carries
    task automatic wait_start(input logic is_rd, output fb_addr_t base);
        int   n;
        logic seen;
        n = 0;
        seen = 1'b0;
        base = '0;
        while (!seen) begin
            @(posedge clk);
            n++;
            if (is_rd ? rd_start : wr_start) begin
                seen = 1'b1;
                base = is_rd ? rd_base : wr_base;
            end else if (n >= EVENT_WAIT) begin
                timed_out(is_rd ? "rd_start_o" : "wr_start_o");
            end
        end
    endtask

    task automatic pulse_done(input logic is_rd, input int width);
        @(posedge clk);
        if (is_rd) begin
            rd_done <= 1'b1;
        end else begin
            wr_done <= 1'b1;
        end
        repeat (width) @(posedge clk);
        rd_done <= 1'b0;
        wr_done <= 1'b0;
    endtask

    // a stream's old slot is retired when that stream starts again
    always @(posedge clk) begin
        if (rst_n) begin
            if (wr_start) begin
                if (wr_held >= 0) begin
                    model = set_slot(model, wr_held, UPDATED);
                end
                mon_exp = expect_base(model, 1'b0, mon_slot);
                if (mon_slot < 0) begin
                    $display("model has no free slot for the writer");
                    errors++;
                end else begin
                    check_addr("wr_base_o", wr_base, mon_exp);
                    model = set_slot(model, mon_slot, WRITE_BUSY);
                end
                wr_held = mon_slot;
            end
            if (rd_start) begin
                if (rd_held >= 0) begin
                    model = set_slot(model, rd_held, DISPLAYED);
                end
                mon_exp = expect_base(model, 1'b1, mon_slot);
                if (mon_slot < 0) begin
                    $display("model has no free slot for the reader");
                    errors++;
                end else begin
                    check_addr("rd_base_o", rd_base, mon_exp);
                    model = set_slot(model, mon_slot, READ_BUSY);
                end
                rd_held = mon_slot;
            end
            if ((wr_start || rd_start) && wr_held >= 0 && rd_held >= 0) begin
                check_distinct(wr_base, rd_base);
            end
        end
    end

    initial begin
        fb_addr_t    base;
        int          err0;
        int          n;
        int          early;
        int          wr_cnt;
        int          rd_cnt;
        logic        seen;
        init_done = 1'b0;
        wr_done = 1'b0;
        rd_done = 1'b0;
        for (int i = 0; i < `FB_NUM_SLOTS; i++) begin
            model = set_slot(model, i, AVAILABLE);
        end
        wr_held = -1;
        rd_held = -1;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        // seeds the generator for the whole run
        void'($urandom(SEED));
        wait_reset();

        err0 = errors;
        pulse_done(1'b0, 1);
        pulse_done(1'b1, 1);
        early = 0;
        repeat (QUIET_SPAN) begin
            @(posedge clk);
            if (wr_start || rd_start) begin
                early++;
            end
        end
        check_count("wr_start_o/rd_start_o before init", early, 0);
        @(posedge clk);
        init_done <= 1'b1;
        n = 0;
        early = 0;
        seen = 1'b0;
        while (!seen) begin
            @(posedge clk);
            n++;
            if (rd_start) begin
                early++;
            end
            if (wr_start) begin
                seen = 1'b1;
                base = wr_base;
            end else if (n >= START_WAIT) begin
                timed_out("the first wr_start_o");
            end
        end
        if (n <= `FB_START_DELAY) begin
            $display("writer started %0d cycles after init, inside the start-up delay", n);
            errors++;
        end
        check_count("rd_start_o before wr_start_o", early, 0);
        end_test("start-up delay", err0);

        err0 = errors;
        check_addr("wr_base_o", base, '0);
        wait_start(1'b1, base);
        check_addr("rd_base_o", base, STRIDE);
        end_test("first claims", err0);

        // writer leaves slot 0 UPDATED and takes free slot 2
        err0 = errors;
        pulse_done(1'b0, 1);
        wait_start(1'b0, base);
        check_addr("wr_base_o", base, STRIDE * 2);
        end_test("writer cycle", err0);

        err0 = errors;
        pulse_done(1'b1, 1);
        wait_start(1'b1, base);
        check_addr("rd_base_o", base, '0);
        end_test("reader cycle", err0);

        err0 = errors;
        for (int k = 0; k < ALT_ROUNDS; k++) begin
            repeat ($urandom_range(6, 0)) @(posedge clk);
            pulse_done(k[0], 1);
            wait_start(k[0], base);
        end
        end_test("random alternation", err0);

        // second cycle of done lands in RELEASE_LOCK
        err0 = errors;
        pulse_done(1'b1, 2);
        wr_cnt = 0;
        rd_cnt = 0;
        repeat (WATCH_SPAN) begin
            @(posedge clk);
            if (wr_start) begin
                wr_cnt++;
            end
            if (rd_start) begin
                rd_cnt++;
            end
        end
        check_count("rd_start_o", rd_cnt, 1);
        check_count("wr_start_o", wr_cnt, 0);
        end_test("ignored done", err0);

        finish_run();
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+rtl
rtl/fb_pkg.sv
rtl/fb_start_delay.sv
rtl/fb_stream_seq.sv
rtl/fb_buffer_broker.sv
rtl/fb_slot.sv
rtl/fb_slot_collect.sv
rtl/fb_manager.sv
dv/fb_clk_gen.sv
dv/fb_manager_tb.sv

//--- Bender.yml
package:
  name: fb_manager

export_include_dirs:
  - rtl

sources:
  - rtl/fb_pkg.sv
  - rtl/fb_start_delay.sv
  - rtl/fb_stream_seq.sv
  - rtl/fb_buffer_broker.sv
  - rtl/fb_slot.sv
  - rtl/fb_slot_collect.sv
  - rtl/fb_manager.sv
  - target: test
    files:
      - dv/fb_clk_gen.sv
      - dv/fb_manager_tb.sv
